// ==== hw/cc_filt.sv ====
`timescale 1ns/1ns
module cc_filt #(
	// half-band smoothing after saturation
	parameter bit use_hb = 1'b1,
	// without the half-band, keep its latency anyway
	parameter bit use_delay = 1'b0
) (
	input  logic                               clk,
	input  logic                               rst_n,
	input  logic [cic_pkg::dw-1:0]             sr_in,
	input  logic                               sr_valid,
	input  logic [cic_pkg::shift_w-1:0]        shift,
	output logic signed [cic_pkg::out_w-1:0]   result,
	output logic                               strobe
);

	logic signed [cic_pkg::dw-1:0]    d2;
	logic                             valid2;
	logic [cic_pkg::shift_w:0]        full_shift;
	logic signed [cic_pkg::dw-1:0]    d2s;
	logic signed [cic_pkg::sat_w-1:0] d3;
	logic                             valid3;
	logic signed [cic_pkg::out_w-1:0] d4;
	logic                             valid4;
	logic signed [cic_pkg::out_w-1:0] d5;
	logic                             valid5;

	// comb section of the CIC
	double_diff diff (
		.clk   (clk),
		.rst_n (rst_n),
		.d_in  (sr_in),
		.g_in  (sr_valid),
		.d_out (d2),
		.g_out (valid2)
	);

	// scale back by the programmed amount, R^2 grows with the period
	assign full_shift = {1'b0, shift} + cic_pkg::shift_base[cic_pkg::shift_w:0];
	assign d2s = d2 >>> full_shift;

	always_ff @(posedge clk) begin
		// keep 21 bits, one over the result for the clamp below
		d3 <= d2s[cic_pkg::sat_w-1:0];
		// clamp on disagreement between the top two bits
		if (d3[cic_pkg::sat_w-1] == d3[cic_pkg::out_w-1])
			d4 <= d3[cic_pkg::out_w-1:0];
		else
			d4 <= {d3[cic_pkg::sat_w-1], {(cic_pkg::out_w-1){~d3[cic_pkg::sat_w-1]}}};
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid3 <= 1'b0;
			valid4 <= 1'b0;
		end else begin
			valid3 <= valid2;
			valid4 <= valid3;
		end
	end

	if (use_hb) begin : g_hb
		half_band hb (
			.clk   (clk),
			.rst_n (rst_n),
			.ind   (d4),
			.ing   (valid4),
			.outd  (d5),
			.outg  (valid5)
		);
	end else if (use_delay) begin : g_delay
		// plain pipe, same length as the half-band
		logic signed [cic_pkg::out_w-1:0] dd [cic_pkg::hb_latency];
		logic [cic_pkg::hb_latency-1:0] dv;
		always_ff @(posedge clk or negedge rst_n) begin
			if (!rst_n) begin
				for (int i = 0; i < cic_pkg::hb_latency; i++)
					dd[i] <= '0;
				dv <= '0;
			end else begin
				dd[0] <= d4;
				for (int i = 1; i < cic_pkg::hb_latency; i++)
					dd[i] <= dd[i-1];
				dv <= {dv[cic_pkg::hb_latency-2:0], valid4};
			end
		end
		assign d5 = dd[cic_pkg::hb_latency-1];
		assign valid5 = dv[cic_pkg::hb_latency-1];
	end else begin : g_direct
		assign d5 = d4;
		assign valid5 = valid4;
	end

	assign result = d5;
	assign strobe = valid5;

	// no output word may escape while held in reset, whichever tail is built
	a_quiet_reset: assert property (@(posedge clk) !rst_n |-> !strobe);

endmodule

// ==== hw/cic_decimator.sv ====
`timescale 1ns/1ns
module cic_decimator (
	input  logic                                      clk,
	input  logic                                      rst_n,
	input  logic [cic_pkg::n_chan*cic_pkg::in_w-1:0]  in_data,
	input  logic                                      in_valid,
	input  logic [cic_pkg::period_w-1:0]              period,
	input  logic [cic_pkg::shift_w-1:0]               shift,
	output logic signed [cic_pkg::out_w-1:0]          result,
	output logic                                      strobe
);

	// serial burst from the integrators, channel 0 first
	logic [cic_pkg::dw-1:0] sr_data;
	logic                   sr_valid;

	cic_integrator_bank bank (
		.clk      (clk),
		.rst_n    (rst_n),
		.in_data  (in_data),
		.in_valid (in_valid),
		.period   (period),
		.sr_data  (sr_data),
		.sr_valid (sr_valid)
	);

	// half-band on, 8 cycles from sr_valid to strobe
	cc_filt #(.use_hb(1'b1), .use_delay(1'b0)) filt (
		.clk      (clk),
		.rst_n    (rst_n),
		.sr_in    (sr_data),
		.sr_valid (sr_valid),
		.shift    (shift),
		.result   (result),
		.strobe   (strobe)
	);

endmodule

// ==== hw/cic_integrator_bank.sv ====
`timescale 1ns/1ns
module cic_integrator_bank (
	input  logic                                       clk,
	input  logic                                       rst_n,
	input  logic [cic_pkg::n_chan*cic_pkg::in_w-1:0]  in_data,
	input  logic                                       in_valid,
	input  logic [cic_pkg::period_w-1:0]               period,
	output logic [cic_pkg::dw-1:0]                     sr_data,
	output logic                                       sr_valid
);

	// input samples widened to the accumulator width
	logic signed [cic_pkg::dw-1:0] x_ext [cic_pkg::n_chan];
	// first and second integrator stage per channel
	logic signed [cic_pkg::dw-1:0] acc1 [cic_pkg::n_chan];
	logic signed [cic_pkg::dw-1:0] acc2 [cic_pkg::n_chan];
	// in_valid count within the current period
	logic [cic_pkg::period_w-1:0] cnt;
	logic snap;
	// serializer, word 0 is on the output
	logic [cic_pkg::dw-1:0] sr [cic_pkg::n_chan];
	// word position inside the running burst
	logic [cic_pkg::ch_w-1:0] bcnt;

	// channel i sits at bits i*in_w upward, sign extend each one
	always_comb begin
		for (int i = 0; i < cic_pkg::n_chan; i++) begin
			x_ext[i] = signed'(in_data[i*cic_pkg::in_w +: cic_pkg::in_w]);
		end
	end

	// period-th valid since the last snapshot
	assign snap = in_valid && (cnt == period - 1'b1);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cnt <= '0;
		end else if (in_valid) begin
			cnt <= snap ? '0 : cnt + 1'b1;
		end
	end

	// two integrators in series, only on valid
	// acc2 picks up the old acc1, one sample of delay per stage
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < cic_pkg::n_chan; i++) begin
				acc1[i] <= '0;
				acc2[i] <= '0;
			end
		end else if (in_valid) begin
			for (int i = 0; i < cic_pkg::n_chan; i++) begin
				acc1[i] <= acc1[i] + x_ext[i];
				acc2[i] <= acc2[i] + acc1[i];
			end
		end
	end

	// snapshot takes the updated second stage, i.e. acc2 + acc1
	// otherwise shift down one word per burst cycle
	always_ff @(posedge clk) begin
		if (snap) begin
			for (int i = 0; i < cic_pkg::n_chan; i++) begin
				sr[i] <= acc2[i] + acc1[i];
			end
		end else if (sr_valid) begin
			for (int i = 0; i < cic_pkg::n_chan - 1; i++) begin
				sr[i] <= sr[i+1];
			end
		end
	end

	// burst runs n_chan cycles starting the cycle after the snapshot
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sr_valid <= 1'b0;
			bcnt <= '0;
		end else if (snap) begin
			sr_valid <= 1'b1;
			bcnt <= '0;
		end else if (sr_valid) begin
			if (bcnt == cic_pkg::last_ch)
				sr_valid <= 1'b0;
			bcnt <= bcnt + 1'b1;
		end
	end

	assign sr_data = sr[0];

	// input spacing must let a burst drain before the next snapshot
	// landing on the last word of a burst is still fine
	a_no_overlap: assert property (@(posedge clk) disable iff (!rst_n)
		snap |-> (!sr_valid || bcnt == cic_pkg::last_ch));

endmodule

// ==== hw/cic_pkg.sv ====
package cic_pkg;

	// channels side by side at the input, one after another on the serial path
	localparam int n_chan = 4;
	// index width for a position inside a serial burst
	localparam int ch_w = $clog2(n_chan);
	// position of the last word in a burst
	localparam logic [ch_w-1:0] last_ch = ch_w'(n_chan - 1);

	// raw input sample width, two's complement
	localparam int in_w = 18;
	// integrator and differentiator width
	// integrators wrap modulo 2^dw, the differentiators undo the wrap
	localparam int dw = 32;

	// final result width
	localparam int out_w = 20;
	// shifted value ahead of saturation, one guard bit over the result
	localparam int sat_w = out_w + 1;

	// runtime scale control
	localparam int shift_w = 4;
	// fixed offset added to the shift, zero for R=4 at shift=0
	localparam int shift_base = 0;

	// decimation period control, R from 4 up to 255
	localparam int period_w = 8;

	// cycles through the half-band stage or its delay substitute
	localparam int hb_latency = 4;
	// half-band accumulator width
	// tap magnitudes sum to 36, so six bits over the sample width
	localparam int hb_w = out_w + 6;

endpackage

// ==== hw/double_diff.sv ====
`timescale 1ns/1ns
module double_diff (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic signed [cic_pkg::dw-1:0] d_in,
	input  logic                          g_in,
	output logic signed [cic_pkg::dw-1:0] d_out,
	output logic                          g_out
);

	// per stage: delay line of n_chan words, one per channel
	logic signed [cic_pkg::dw-1:0] dl [2][cic_pkg::n_chan];
	// stage inputs
	logic signed [cic_pkg::dw-1:0] st_d [2];
	logic                          st_g [2];
	// stage outputs, registered
	logic signed [cic_pkg::dw-1:0] st_q [2];
	logic                          st_v [2];
	// valid run length modulo n_chan, for the burst check
	logic [cic_pkg::ch_w-1:0] run;

	// stage 0 eats the input, stage 1 eats stage 0
	always_comb begin
		st_d[0] = d_in;
		st_g[0] = g_in;
		st_d[1] = st_q[0];
		st_g[1] = st_v[0];
	end

	// oldest word in the line is the same channel one burst back
	// line only moves on valid so gaps between bursts do no harm
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int s = 0; s < 2; s++) begin
				for (int i = 0; i < cic_pkg::n_chan; i++)
					dl[s][i] <= '0;
				st_q[s] <= '0;
				st_v[s] <= 1'b0;
			end
		end else begin
			for (int s = 0; s < 2; s++) begin
				st_v[s] <= st_g[s];
				if (st_g[s]) begin
					st_q[s] <= st_d[s] - dl[s][cic_pkg::n_chan-1];
					dl[s][0] <= st_d[s];
					for (int i = 1; i < cic_pkg::n_chan; i++)
						dl[s][i] <= dl[s][i-1];
				end
			end
		end
	end

	assign d_out = st_q[1];
	assign g_out = st_v[1];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			run <= '0;
		else if (g_in)
			run <= (run == cic_pkg::last_ch) ? '0 : run + 1'b1;
		else
			run <= '0;
	end

	// a stretch of valids is made of whole n_chan bursts,
	// otherwise channels slip in the delay lines
	a_burst_len: assert property (@(posedge clk) disable iff (!rst_n)
		$fell(g_in) |-> run == '0);

endmodule

// ==== hw/half_band.sv ====
`timescale 1ns/1ns
module half_band (
	input  logic                             clk,
	input  logic                             rst_n,
	input  logic signed [cic_pkg::out_w-1:0] ind,
	input  logic                             ing,
	output logic signed [cic_pkg::out_w-1:0] outd,
	output logic                             outg
);

	// six past samples per channel, same channel k back at k*n_chan-1
	logic signed [cic_pkg::out_w-1:0] line [6*cic_pkg::n_chan];
	// stage 1: pairs folded around the center tap
	logic signed [cic_pkg::hb_w-1:0] s1_outer;
	logic signed [cic_pkg::hb_w-1:0] s1_inner;
	logic signed [cic_pkg::hb_w-1:0] s1_mid;
	// stage 2: weighted partial sums
	logic signed [cic_pkg::hb_w-1:0] s2_nine;
	logic signed [cic_pkg::hb_w-1:0] s2_rest;
	// stage 3: full sum, 32 times the output
	logic signed [cic_pkg::hb_w-1:0] s3_sum;
	// rounded, scaled and clamped
	logic signed [cic_pkg::hb_w-1:0] y_sh;
	logic signed [cic_pkg::out_w-1:0] y_sat;
	logic [cic_pkg::hb_latency-1:0] vpipe;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < 6*cic_pkg::n_chan; i++)
				line[i] <= '0;
		end else if (ing) begin
			line[0] <= ind;
			for (int i = 1; i < 6*cic_pkg::n_chan; i++)
				line[i] <= line[i-1];
		end
	end

	// taps -1 0 9 16 9 0 -1, odd taps beside the center are zero
	always_ff @(posedge clk) begin
		s1_outer <= ind + line[6*cic_pkg::n_chan-1];
		s1_inner <= line[2*cic_pkg::n_chan-1] + line[4*cic_pkg::n_chan-1];
		s1_mid   <= line[3*cic_pkg::n_chan-1];
		// 9x as 8x + x, 16x as a plain shift
		s2_nine  <= (s1_inner <<< 3) + s1_inner;
		s2_rest  <= (s1_mid <<< 4) - s1_outer;
		s3_sum   <= s2_nine + s2_rest;
		outd     <= y_sat;
	end

	// divide by 32 with round half up, a settled input comes back unchanged
	always_comb begin
		y_sh = s3_sum + $signed(6'd16);
		y_sh = y_sh >>> 5;
		// all upper bits equal to the new sign bit means it fits
		if (~|y_sh[cic_pkg::hb_w-1:cic_pkg::out_w-1] || &y_sh[cic_pkg::hb_w-1:cic_pkg::out_w-1])
			y_sat = y_sh[cic_pkg::out_w-1:0];
		else
			y_sat = {y_sh[cic_pkg::hb_w-1], {(cic_pkg::out_w-1){~y_sh[cic_pkg::hb_w-1]}}};
	end

	// valid walks alongside the four data stages
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			vpipe <= '0;
		else
			vpipe <= {vpipe[cic_pkg::hb_latency-2:0], ing};
	end

	assign outg = vpipe[cic_pkg::hb_latency-1];

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build with Verilator and run, pass only when the sim prints its pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f src.f \
	--top-module cic_decimator_tb -o cic_sim &&
./obj_dir/cic_sim | tee /dev/stderr | grep -q "^Test OK$" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

// ==== src.f ====
+incdir+test
hw/cic_pkg.sv
hw/cic_integrator_bank.sv
hw/double_diff.sv
hw/half_band.sv
hw/cc_filt.sv
hw/cic_decimator.sv
test/cic_decimator_tb.sv

// ==== test/cic_tb_tasks.svh ====
// settled output for a constant x: x*R^2, arithmetic shift,
// keep 21 bits, then clamp to the result range
function automatic int expected_out(input int x, input int r, input int sh);
	longint prod;
	logic signed [cic_pkg::out_w:0] kept;
	prod = longint'(x) * longint'(r) * longint'(r);
	prod = prod >>> (sh + cic_pkg::shift_base);
	kept = prod[cic_pkg::out_w:0];
	if (kept > sat_max)
		return sat_max;
	if (kept < sat_min)
		return sat_min;
	return int'(kept);
endfunction

// reset, feed frames*r samples on every other cycle, then check the settled bursts
task automatic run_case(input int r, input int sh, input int frames, input string name);
	int exp;
	#1;
	rst_n = 1'b0;
	in_valid = 1'b0;
	period = r[cic_pkg::period_w-1:0];
	shift = sh[cic_pkg::shift_w-1:0];
	for (int i = 0; i < cic_pkg::n_chan; i++)
		in_data[i*cic_pkg::in_w +: cic_pkg::in_w] = xin[i][cic_pkg::in_w-1:0];
	repeat (16) @(posedge clk);
	#1 rst_n = 1'b1;
	repeat (frames * r) begin
		@(posedge clk);
		#1 in_valid = 1'b1;
		@(posedge clk);
		#1 in_valid = 1'b0;
	end
	while (bursts < frames)
		@(posedge clk);
	// idle a while, a stray extra burst would show up here
	repeat (16) @(posedge clk);
	if (bursts != frames) begin
		proto_errs++;
		$display("%s: %0d bursts for %0d periods of input", name, bursts, frames);
	end
	for (int b = settle_frames; b < frames; b++) begin
		for (int ch = 0; ch < cic_pkg::n_chan; ch++) begin
			exp = expected_out(xin[ch], r, sh);
			checks++;
			if (got[ch][b] != exp) begin
				value_errs++;
				$display("ERROR %0t ns: %s burst %0d channel %0d gave %0d, expected %0d",
					$time, name, b, ch, got[ch][b], exp);
			end
		end
	end
endtask

// R=4 and no shift, 16x each value in channel order
task automatic test_distinct();
	xin = '{1000, 23456, 77, 32767};
	run_case(4, 0, 16, "distinct");
endtask

task automatic test_random();
	for (int k = 0; k < 2; k++) begin
		for (int i = 0; i < cic_pkg::n_chan; i++)
			xin[i] = $random(seed) % (1 << (cic_pkg::in_w - 1));
		run_case(16, 4, 12, "random");
	end
endtask

// shift of 7 at R=8 leaves odd halves, rounding goes toward minus infinity
task automatic test_negative();
	xin = '{-1, -300, -5001, -65536};
	run_case(8, 7, 12, "negative");
endtask

// 16x lands beyond 20 bits but inside 21, so both rails get hit
task automatic test_clamp();
	xin = '{40000, -40000, 65000, -65000};
	run_case(4, 0, 12, "clamp");
endtask

// ==== test/cic_decimator_tb.sv ====
`timescale 1ns/1ns
module cic_decimator_tb;

	// per case: 16 reset cycles plus 32 for drain and idle check,
	// then two cycles per in_valid over all frames
	localparam int test_cycles = 5 * (16 + 32)
		+ 2 * (4 * 16 + 2 * 16 * 12 + 8 * 12 + 4 * 12);
	localparam int max_cycles = 2 * test_cycles;
	// bursts recorded per case, and how many to skip while the filters settle
	localparam int max_frames = 16;
	localparam int settle_frames = 8;
	localparam int sat_max = (1 << (cic_pkg::out_w - 1)) - 1;
	localparam int sat_min = -(1 << (cic_pkg::out_w - 1));

	logic                                     clk;
	logic                                     rst_n;
	logic [cic_pkg::n_chan*cic_pkg::in_w-1:0] in_data;
	logic                                     in_valid;
	logic [cic_pkg::period_w-1:0]             period;
	logic [cic_pkg::shift_w-1:0]              shift;
	logic signed [cic_pkg::out_w-1:0]         result;
	logic                                     strobe;

	// constant input per channel for the running case
	int xin [cic_pkg::n_chan];
	// results by channel and burst index
	int got [cic_pkg::n_chan][max_frames];
	int run = 0;
	int bursts = 0;
	int vcount = 0;
	int value_errs = 0;
	int proto_errs = 0;
	int checks = 0;
	int cycles = 0;
	integer seed = 32'h572c_85ff;

	cic_decimator dut_i (
		.clk      (clk),
		.rst_n    (rst_n),
		.in_data  (in_data),
		.in_valid (in_valid),
		.period   (period),
		.shift    (shift),
		.result   (result),
		.strobe   (strobe)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// sample on the falling edge, half a cycle clear of any update
	// channel index is the position inside the burst
	always @(negedge clk) begin
		if (!rst_n) begin
			if (strobe) begin
				proto_errs++;
				$display("strobe went high while reset was asserted at %0t ns", $time);
			end
			vcount = 0;
			run = 0;
			bursts = 0;
		end else begin
			if (in_valid)
				vcount++;
			if (strobe) begin
				// nothing may come out before one whole period was fed in
				if (vcount < int'(period)) begin
					proto_errs++;
					$display("strobe came after only %0d input samples at %0t ns",
						vcount, $time);
				end
				if (run < cic_pkg::n_chan && bursts < max_frames)
					got[run][bursts] = int'(result);
				run++;
			end else if (run != 0) begin
				if (run != cic_pkg::n_chan) begin
					proto_errs++;
					$display("burst of %0d strobes where %0d were due, at %0t ns",
						run, cic_pkg::n_chan, $time);
				end
				bursts++;
				run = 0;
			end
		end
	end

	task automatic end_run(input bit timed_out);
		$display("errors: %0d value, %0d protocol, over %0d value checks",
			value_errs, proto_errs, checks);
		if (!timed_out && value_errs == 0 && proto_errs == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	endtask

	`include "cic_tb_tasks.svh"

	initial begin
		rst_n = 1'b0;
		in_valid = 1'b0;
		in_data = '0;
		period = '0;
		shift = '0;
		test_distinct();
		test_random();
		test_negative();
		test_clamp();
		end_run(1'b0);
	end

	// stuck waiting on bursts that never come
	initial begin
		while (cycles < max_cycles) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: the run did not end within %0d cycles", max_cycles);
		end_run(1'b1);
	end

endmodule
